/* source/dfTypesPkg.sv */
//------------------------------
// Datapath types for the decimation chain
// Sample, accumulator and coefficient vectors,
// half-band taps, CIC order, saturation helper
//------------------------------
package dfTypesPkg;
    localparam int sampleWidth = 18;
    localparam int sampleFrac = 17;
    localparam int cicAccWidth = 48;
    localparam int hbAccWidth = 40;
    localparam int hbTaps = 11;
    localparam int cicOrder = 3;

    typedef logic signed [sampleWidth-1:0] sampleT;
    typedef logic signed [cicAccWidth-1:0] cicAccT;
    typedef logic signed [hbAccWidth-1:0] hbAccT;
    typedef logic signed [sampleWidth-1:0] hbCoefT;

    // Outer taps sum to one quarter, centre tap is one half
    localparam hbCoefT hbCoef0 = 18'sd1536;
    localparam hbCoefT hbCoef2 = -18'sd7640;
    localparam hbCoefT hbCoef4 = 18'sd38872;

    // Clamp a wide signed value into the sample range
    function automatic sampleT satSample(input cicAccT value);
        cicAccT maxVal;
        cicAccT minVal;
        maxVal = cicAccT'(2 ** (sampleWidth - 1) - 1);
        minVal = -cicAccT'(2 ** (sampleWidth - 1));
        if (value > maxVal) begin
            return sampleT'(maxVal);
        end else if (value < minVal) begin
            return sampleT'(minVal);
        end
        return sampleT'(value);
    endfunction
endpackage

/* source/dfRegMapPkg.sv */
//------------------------------
// Register map of the filter space
// Bus types, addresses, field positions,
// reset values
//------------------------------
package dfRegMapPkg;
    typedef logic [12:0] regAddrT;
    typedef logic [31:0] busWordT;
    typedef logic [14:0] rateT;
    typedef logic [5:0] shiftT;

    // Sixteen word block at 0x200
    localparam regAddrT dfSpaceMask = 13'h1ff0;
    localparam regAddrT ctrlAddr = 13'h0200;
    localparam regAddrT cicAddr = 13'h0201;

    // Control register bits
    localparam int bypassHb0Bit = 0;
    localparam int bypassCicBit = 1;
    localparam int bypassHb1Bit = 2;

    // CIC register fields
    localparam int rateLsb = 0;
    localparam int shiftLsb = 16;

    // All stages bypassed, rate 4 with shift 6
    localparam busWordT ctrlReset = 32'h0000_0007;
    localparam busWordT cicReset = 32'h0006_0004;
endpackage

/* source/dfCfgIf.sv */
//------------------------------
// Configuration bundle from the
// register bank to the datapath
//------------------------------
`timescale 1ns/1ps

interface dfCfgIf;
    logic bypassHb0;
    logic bypassCic;
    logic bypassHb1;
    dfRegMapPkg::rateT cicRate;
    dfRegMapPkg::shiftT cicShift;

    modport regs (
        output bypassHb0, bypassCic, bypassHb1,
        output cicRate, cicShift
    );

    modport filt (
        input bypassHb0, bypassCic, bypassHb1,
        input cicRate, cicShift
    );
endinterface

/* source/dfRegs.sv */
//------------------------------
// Control and CIC registers with
// byte lane writes and read-back mux
//------------------------------
`timescale 1ns/1ps

module dfRegs (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  cs,
    input  dfRegMapPkg::regAddrT  addr,
    input  dfRegMapPkg::busWordT  din,
    input  logic                  wr0,
    input  logic                  wr1,
    input  logic                  wr2,
    input  logic                  wr3,
    output dfRegMapPkg::busWordT  dout,
    dfCfgIf.regs                  cfg
);
    dfRegMapPkg::busWordT ctrlReg;
    dfRegMapPkg::busWordT cicReg;
    logic [3:0] laneWr;
    logic ctrlSel;
    logic cicSel;

    // Replace only the bytes whose lane strobe is set
    function automatic dfRegMapPkg::busWordT mergeLanes(
        input dfRegMapPkg::busWordT cur,
        input dfRegMapPkg::busWordT wdata,
        input logic [3:0] lanes
    );
        dfRegMapPkg::busWordT merged;
        merged = cur;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return merged;
    endfunction

    assign laneWr = {wr3, wr2, wr1, wr0};
    assign ctrlSel = cs && (addr == dfRegMapPkg::ctrlAddr);
    assign cicSel = cs && (addr == dfRegMapPkg::cicAddr);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ctrlReg <= dfRegMapPkg::ctrlReset;
            cicReg <= dfRegMapPkg::cicReset;
        end else begin
            if (ctrlSel) begin
                ctrlReg <= mergeLanes(ctrlReg, din, laneWr);
            end
            if (cicSel) begin
                cicReg <= mergeLanes(cicReg, din, laneWr);
            end
        end
    end

    // Unmapped words and other spaces read as zero
    always_comb begin
        dout = '0;
        if (ctrlSel) begin
            dout = ctrlReg;
        end else if (cicSel) begin
            dout = cicReg;
        end
    end

    // Field extraction toward the datapath
    assign cfg.bypassHb0 = ctrlReg[dfRegMapPkg::bypassHb0Bit];
    assign cfg.bypassCic = ctrlReg[dfRegMapPkg::bypassCicBit];
    assign cfg.bypassHb1 = ctrlReg[dfRegMapPkg::bypassHb1Bit];
    assign cfg.cicRate = cicReg[dfRegMapPkg::rateLsb +: $bits(dfRegMapPkg::rateT)];
    assign cfg.cicShift = cicReg[dfRegMapPkg::shiftLsb +: $bits(dfRegMapPkg::shiftT)];
endmodule

/* source/halfbandDecimate.sv */
//------------------------------
// 11-tap half-band filter, decimate by 2
// Symmetric pair adds, fixed taps,
// rounding and saturation
//------------------------------
`timescale 1ns/1ps

module halfbandDecimate (
    input  logic                clk,
    input  logic                rstN,
    input  logic                strobe,
    input  dfTypesPkg::sampleT  din,
    output logic                strobeOut,
    output dfTypesPkg::sampleT  dout
);
    localparam int lastTap = dfTypesPkg::hbTaps - 1;
    localparam int centreTap = dfTypesPkg::hbTaps / 2;

    dfTypesPkg::sampleT line [dfTypesPkg::hbTaps];
    logic phase;
    logic signed [dfTypesPkg::sampleWidth:0] pairOuter;
    logic signed [dfTypesPkg::sampleWidth:0] pairMid;
    logic signed [dfTypesPkg::sampleWidth:0] pairInner;
    dfTypesPkg::hbAccT acc;
    dfTypesPkg::hbAccT rounded;

    // Delay line with the newest sample in line[0]
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < dfTypesPkg::hbTaps; i++) begin
                line[i] <= '0;
            end
        end else if (strobe) begin
            line[0] <= din;
            for (int i = 1; i < dfTypesPkg::hbTaps; i++) begin
                line[i] <= line[i-1];
            end
        end
    end

    // Every second accepted sample produces a result
    always_ff @(posedge clk) begin
        if (!rstN) begin
            phase <= 1'b0;
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= strobe & phase;
            if (strobe) begin
                phase <= ~phase;
            end
        end
    end

    // Odd taps other than the centre are zero
    always_comb begin
        pairOuter = line[0] + line[lastTap];
        pairMid = line[2] + line[lastTap-2];
        pairInner = line[4] + line[lastTap-4];
    end

    // Q34 sum with the centre tap of one half done as a shift
    always_comb begin
        acc = pairOuter * dfTypesPkg::hbCoef0
            + pairMid * dfTypesPkg::hbCoef2
            + pairInner * dfTypesPkg::hbCoef4
            + (dfTypesPkg::hbAccT'(line[centreTap]) <<< (dfTypesPkg::sampleFrac - 1));
        rounded = (acc + (dfTypesPkg::hbAccT'(1) <<< (dfTypesPkg::sampleFrac - 1)))
            >>> dfTypesPkg::sampleFrac;
    end

    // Line only moves on a strobe, so this holds while strobeOut is high
    assign dout = dfTypesPkg::satSample(dfTypesPkg::cicAccT'(rounded));
endmodule

/* source/cicDecimator.sv */
//------------------------------
// Third-order CIC decimator
// Programmable rate, output gain shift,
// saturation to sample width
//------------------------------
`timescale 1ns/1ps

module cicDecimator (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 strobe,
    input  dfTypesPkg::sampleT   din,
    input  dfRegMapPkg::rateT    rate,
    input  dfRegMapPkg::shiftT   shift,
    output logic                 strobeOut,
    output dfTypesPkg::sampleT   dout
);
    dfTypesPkg::cicAccT integ [dfTypesPkg::cicOrder];
    dfTypesPkg::cicAccT combDly [dfTypesPkg::cicOrder];
    dfTypesPkg::cicAccT combStage [dfTypesPkg::cicOrder + 1];
    dfTypesPkg::cicAccT scaled;
    dfRegMapPkg::rateT count;
    logic tick;

    // Decimation point when the down-counter has run out
    assign tick = strobe && (count == '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (strobe) begin
            if (count == '0) begin
                count <= rate - 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Integrator cascade at the input rate
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < dfTypesPkg::cicOrder; k++) begin
                integ[k] <= '0;
            end
        end else if (strobe) begin
            integ[0] <= integ[0] + dfTypesPkg::cicAccT'(din);
            for (int k = 1; k < dfTypesPkg::cicOrder; k++) begin
                integ[k] <= integ[k] + integ[k-1];
            end
        end
    end

    // Comb cascade on the decimated samples
    always_comb begin
        combStage[0] = integ[dfTypesPkg::cicOrder - 1];
        for (int k = 0; k < dfTypesPkg::cicOrder; k++) begin
            combStage[k+1] = combStage[k] - combDly[k];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int k = 0; k < dfTypesPkg::cicOrder; k++) begin
                combDly[k] <= '0;
            end
        end else if (tick) begin
            for (int k = 0; k < dfTypesPkg::cicOrder; k++) begin
                combDly[k] <= combStage[k];
            end
        end
    end

    // Gain of rate cubed removed by the shift
    assign scaled = combStage[dfTypesPkg::cicOrder] >>> shift;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= tick;
        end
    end

    always_ff @(posedge clk) begin
        if (tick) begin
            dout <= dfTypesPkg::satSample(scaled);
        end
    end
endmodule

/* source/decimatingFilter.sv */
//------------------------------
// Decimating filter channel top
// Address decode, register bank,
// bypass routing, hb0 / CIC / hb1 chain,
// output register
//------------------------------
`timescale 1ns/1ps

module decimatingFilter (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  clkEn,
    input  dfTypesPkg::sampleT    rx,
    input  dfRegMapPkg::regAddrT  addr,
    input  dfRegMapPkg::busWordT  din,
    input  logic                  wr0,
    input  logic                  wr1,
    input  logic                  wr2,
    input  logic                  wr3,
    output dfRegMapPkg::busWordT  dout,
    output logic                  clkEnOut,
    output dfTypesPkg::sampleT    dfOut
);
    logic dfSpace;
    dfTypesPkg::sampleT hb0In;
    dfTypesPkg::sampleT hb0Out;
    dfTypesPkg::sampleT cicIn;
    dfTypesPkg::sampleT cicOut;
    dfTypesPkg::sampleT hb1In;
    dfTypesPkg::sampleT hb1Out;
    dfTypesPkg::sampleT afterHb0;
    dfTypesPkg::sampleT afterCic;
    dfTypesPkg::sampleT afterHb1;
    logic hb0ClkEn;
    logic hb0ClkEnOut;
    logic cicClkEn;
    logic cicClkEnOut;
    logic hb1ClkEn;
    logic hb1ClkEnOut;
    logic afterHb0En;
    logic afterCicEn;
    logic afterHb1En;

    dfCfgIf cfg ();

    assign dfSpace = (addr & dfRegMapPkg::dfSpaceMask)
        == (dfRegMapPkg::ctrlAddr & dfRegMapPkg::dfSpaceMask);

    dfRegs ctrlRegs (
        .clk(clk), .rstN(rstN), .cs(dfSpace),
        .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout), .cfg(cfg)
    );

    // Nearest live source after each stage position
    always_comb begin
        afterHb0 = cfg.bypassHb0 ? rx : hb0Out;
        afterHb0En = cfg.bypassHb0 ? clkEn : hb0ClkEnOut;
        afterCic = cfg.bypassCic ? afterHb0 : cicOut;
        afterCicEn = cfg.bypassCic ? afterHb0En : cicClkEnOut;
        afterHb1 = cfg.bypassHb1 ? afterCic : hb1Out;
        afterHb1En = cfg.bypassHb1 ? afterCicEn : hb1ClkEnOut;
    end

    // Stage input strobes, held low while the stage is bypassed
    always_ff @(posedge clk) begin
        if (!rstN) begin
            hb0ClkEn <= 1'b0;
            cicClkEn <= 1'b0;
            hb1ClkEn <= 1'b0;
            clkEnOut <= 1'b0;
        end else begin
            hb0ClkEn <= clkEn & ~cfg.bypassHb0;
            cicClkEn <= afterHb0En & ~cfg.bypassCic;
            hb1ClkEn <= afterCicEn & ~cfg.bypassHb1;
            clkEnOut <= afterHb1En;
        end
    end

    // Zeroed data keeps a bypassed stage quiet
    always_ff @(posedge clk) begin
        hb0In <= cfg.bypassHb0 ? '0 : rx;
        cicIn <= cfg.bypassCic ? '0 : afterHb0;
        hb1In <= cfg.bypassHb1 ? '0 : afterCic;
        dfOut <= afterHb1;
    end

    halfbandDecimate hb0 (
        .clk(clk), .rstN(rstN), .strobe(hb0ClkEn), .din(hb0In),
        .strobeOut(hb0ClkEnOut), .dout(hb0Out)
    );

    cicDecimator cic (
        .clk(clk), .rstN(rstN), .strobe(cicClkEn), .din(cicIn),
        .rate(cfg.cicRate), .shift(cfg.cicShift),
        .strobeOut(cicClkEnOut), .dout(cicOut)
    );

    halfbandDecimate hb1 (
        .clk(clk), .rstN(rstN), .strobe(hb1ClkEn), .din(hb1In),
        .strobeOut(hb1ClkEnOut), .dout(hb1Out)
    );
endmodule

/* tests/decimatingFilter_props.sv */
//------------------------------
// Bound checks on the filter top
// clkEnOut around reset, bypassed stage
// strobes, all-bypass strobe delay
//------------------------------
`timescale 1ns/1ps

module dfProps (
    input logic clk,
    input logic rstN,
    input logic clkEn,
    input logic clkEnOut,
    input logic hb0Strobe,
    input logic cicStrobe,
    input logic hb1Strobe,
    input logic bypassHb0,
    input logic bypassCic,
    input logic bypassHb1
);
    logic strobeSeen;

    // Set by the first input strobe after reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeSeen <= 1'b0;
        end else if (clkEn) begin
            strobeSeen <= 1'b1;
        end
    end

    outQuietInReset: assert property (@(posedge clk) !rstN |=> !clkEnOut)
        else $error("clkEnOut high in the cycle after a reset cycle");

    outNeedsInput: assert property (@(posedge clk) disable iff (!rstN)
        clkEnOut |-> strobeSeen)
        else $error("clkEnOut high before any input strobe");

    // Stage strobes are registered, so the bypass bit of the cycle before applies
    hb0Quiet: assert property (@(posedge clk) disable iff (!rstN)
        $past(bypassHb0) |-> !hb0Strobe)
        else $error("hb0 strobe high while hb0 is bypassed");

    cicQuiet: assert property (@(posedge clk) disable iff (!rstN)
        $past(bypassCic) |-> !cicStrobe)
        else $error("CIC strobe high while the CIC is bypassed");

    hb1Quiet: assert property (@(posedge clk) disable iff (!rstN)
        $past(bypassHb1) |-> !hb1Strobe)
        else $error("hb1 strobe high while hb1 is bypassed");

    bypassDelay: assert property (@(posedge clk) disable iff (!rstN)
        (bypassHb0 && bypassCic && bypassHb1) |=> (clkEnOut == $past(clkEn)))
        else $error("clkEnOut is not clkEn delayed by one cycle in full bypass");
endmodule

bind decimatingFilter dfProps props (
    .clk(clk), .rstN(rstN), .clkEn(clkEn), .clkEnOut(clkEnOut),
    .hb0Strobe(hb0ClkEn), .cicStrobe(cicClkEn), .hb1Strobe(hb1ClkEn),
    .bypassHb0(cfg.bypassHb0), .bypassCic(cfg.bypassCic), .bypassHb1(cfg.bypassHb1)
);

/* tests/dfTb.sv */
//------------------------------
// Testbench for the decimating filter
// Clock, reset, bus access, stimulus,
// output counting, timeout
//------------------------------
`timescale 1ns/1ps

module dfTb;
    localparam int resetCycles = 5;
    localparam int settleCycles = 4;
    localparam int flushCycles = 8;
    localparam int regCycles = 60;
    localparam int bypassCycles = 200;
    localparam int hbStrobes = 64;
    localparam int cicStrobesA = 64;
    localparam int cicStrobesB = 128;
    localparam int chainStrobes = 512;
    localparam int totalStrobes = hbStrobes + cicStrobesA + cicStrobesB + chainStrobes;
    // Random strobes arrive on about half of the cycles
    localparam int stimCycles = resetCycles + regCycles + bypassCycles + 2 * totalStrobes
        + 5 * (settleCycles + flushCycles + 2);
    localparam int timeoutCycles = 2 * stimCycles;
    localparam dfRegMapPkg::regAddrT outsideAddr = 13'h0601;

    logic clk;
    logic rstN;
    logic clkEn;
    dfTypesPkg::sampleT rx;
    dfRegMapPkg::regAddrT addr;
    dfRegMapPkg::busWordT din;
    logic wr0;
    logic wr1;
    logic wr2;
    logic wr3;
    dfRegMapPkg::busWordT dout;
    logic clkEnOut;
    dfTypesPkg::sampleT dfOut;
    int cycleCount = 0;
    dfRegMapPkg::busWordT ctrlModel;
    dfRegMapPkg::busWordT cicModel;

    decimatingFilter u_decimatingFilter (
        .clk(clk), .rstN(rstN), .clkEn(clkEn), .rx(rx), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .dout(dout), .clkEnOut(clkEnOut), .dfOut(dfOut)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeoutCycles);
            $display("tests failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic failRun(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    // Expected register value after a byte-lane write
    function automatic dfRegMapPkg::busWordT laneMerge(input dfRegMapPkg::busWordT old,
            input dfRegMapPkg::busWordT data, input logic [3:0] lanes);
        dfRegMapPkg::busWordT mask;
        mask = {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
        return (old & ~mask) | (data & mask);
    endfunction

    function automatic dfTypesPkg::sampleT randomLevel();
        return dfTypesPkg::sampleT'(int'($urandom_range(0, 65535)) - 32768);
    endfunction

    task automatic busWrite(input dfRegMapPkg::regAddrT a, input dfRegMapPkg::busWordT data,
            input logic [3:0] lanes);
        addr = a;
        din = data;
        {wr3, wr2, wr1, wr0} = lanes;
        nextCycle();
        {wr3, wr2, wr1, wr0} = 4'b0000;
    endtask

    task automatic readCheck(input dfRegMapPkg::regAddrT a, input dfRegMapPkg::busWordT expected,
            input string label);
        dfRegMapPkg::busWordT got;
        addr = a;
        #1;
        got = dout;
        assert (got == expected) else
            failRun($sformatf("%s read %h, expected %h", label, got, expected));
        nextCycle();
    endtask

    task automatic configure(input logic skipHb0, input logic skipCic, input logic skipHb1,
            input int rate);
        dfRegMapPkg::busWordT ctrlWord;
        dfRegMapPkg::busWordT cicWord;
        ctrlWord = '0;
        ctrlWord[dfRegMapPkg::bypassHb0Bit] = skipHb0;
        ctrlWord[dfRegMapPkg::bypassCicBit] = skipCic;
        ctrlWord[dfRegMapPkg::bypassHb1Bit] = skipHb1;
        // Gain R cubed is undone by a shift of 3 log2 R
        cicWord = '0;
        cicWord[dfRegMapPkg::rateLsb +: 15] = dfRegMapPkg::rateT'(rate);
        cicWord[dfRegMapPkg::shiftLsb +: 6] = dfRegMapPkg::shiftT'(3 * $clog2(rate));
        busWrite(dfRegMapPkg::cicAddr, cicWord, 4'hf);
        busWrite(dfRegMapPkg::ctrlAddr, ctrlWord, 4'hf);
        repeat (settleCycles) nextCycle();
    endtask

    task automatic checkRegisters();
        dfRegMapPkg::busWordT data;
        logic [3:0] lanes;
        logic pickCic;
        ctrlModel = dfRegMapPkg::ctrlReset;
        cicModel = dfRegMapPkg::cicReset;
        readCheck(dfRegMapPkg::ctrlAddr, ctrlModel, "control after reset");
        readCheck(dfRegMapPkg::cicAddr, cicModel, "CIC after reset");
        readCheck(outsideAddr, '0, "address outside the space");
        for (int i = 0; i < 12; i++) begin
            pickCic = 1'($urandom);
            data = $urandom;
            lanes = 4'($urandom);
            busWrite(pickCic ? dfRegMapPkg::cicAddr : dfRegMapPkg::ctrlAddr, data, lanes);
            if (pickCic) begin
                cicModel = laneMerge(cicModel, data, lanes);
            end else begin
                ctrlModel = laneMerge(ctrlModel, data, lanes);
            end
            readCheck(dfRegMapPkg::ctrlAddr, ctrlModel, "control after write");
            readCheck(dfRegMapPkg::cicAddr, cicModel, "CIC after write");
        end
        // Same register offset in another block
        busWrite(outsideAddr, 32'hffff_ffff, 4'hf);
        readCheck(dfRegMapPkg::ctrlAddr, ctrlModel, "control after outside write");
        readCheck(dfRegMapPkg::cicAddr, cicModel, "CIC after outside write");
        readCheck(outsideAddr, '0, "address outside the space after write");
    endtask

    task automatic checkBypassPath(input int cycles);
        dfTypesPkg::sampleT prevRx;
        logic prevEn;
        for (int i = 0; i < cycles; i++) begin
            prevRx = rx;
            prevEn = clkEn;
            nextCycle();
            assert (clkEnOut == prevEn) else
                failRun($sformatf("bypass clkEnOut %b, expected %b", clkEnOut, prevEn));
            assert (dfOut == prevRx) else
                failRun($sformatf("bypass dfOut %0d, expected %0d", dfOut, prevRx));
            rx = dfTypesPkg::sampleT'($urandom);
            clkEn = 1'($urandom);
        end
        clkEn = 1'b0;
        rx = '0;
    endtask

    task automatic collectOutput(inout int outCount, inout dfTypesPkg::sampleT lastOut);
        nextCycle();
        if (clkEnOut) begin
            outCount++;
            lastOut = dfOut;
        end
    endtask

    task automatic runConstant(input dfTypesPkg::sampleT value, input int numStrobes,
            input int expectedOut, input int tolerance, input string label);
        int issued;
        int outCount;
        int diff;
        dfTypesPkg::sampleT lastOut;
        issued = 0;
        outCount = 0;
        lastOut = '0;
        while (issued < numStrobes) begin
            clkEn = 1'($urandom);
            // Idle cycles carry noise that no stage may take in
            rx = clkEn ? value : dfTypesPkg::sampleT'($urandom);
            issued += int'(clkEn);
            collectOutput(outCount, lastOut);
        end
        clkEn = 1'b0;
        rx = '0;
        while (outCount < expectedOut) begin
            collectOutput(outCount, lastOut);
        end
        // Any strobe later than the 7 cycle chain latency is extra
        repeat (flushCycles) collectOutput(outCount, lastOut);
        assert (outCount == expectedOut) else
            failRun($sformatf("%s gave %0d output strobes, expected %0d",
                label, outCount, expectedOut));
        diff = int'(lastOut) - int'(value);
        assert (diff <= tolerance && diff >= -tolerance) else
            failRun($sformatf("%s settled at %0d, expected %0d", label, lastOut, value));
    endtask

    initial begin
        void'($urandom(32'h0d0734d1));
        rstN = 1'b0;
        clkEn = 1'b0;
        rx = '0;
        addr = '0;
        din = '0;
        {wr3, wr2, wr1, wr0} = 4'b0000;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;

        checkRegisters();
        configure(1'b1, 1'b1, 1'b1, 4);
        checkBypassPath(bypassCycles);
        configure(1'b0, 1'b1, 1'b1, 4);
        runConstant(randomLevel(), hbStrobes, hbStrobes / 2, 1, "hb0 only");
        configure(1'b1, 1'b0, 1'b1, 4);
        runConstant(randomLevel(), cicStrobesA, cicStrobesA / 4, 1, "CIC only rate 4");
        configure(1'b1, 1'b0, 1'b1, 8);
        runConstant(randomLevel(), cicStrobesB, cicStrobesB / 8, 1, "CIC only rate 8");
        configure(1'b0, 1'b0, 1'b0, 4);
        runConstant(randomLevel(), chainStrobes, chainStrobes / 16, 2, "full chain rate 4");

        $display("all tests passed");
        $finish;
    end
endmodule

/* tb.f */
source/dfTypesPkg.sv
source/dfRegMapPkg.sv
source/dfCfgIf.sv
source/dfRegs.sv
source/halfbandDecimate.sv
source/cicDecimator.sv
source/decimatingFilter.sv
tests/decimatingFilter_props.sv
tests/dfTb.sv

/* run.sh */
#!/bin/sh
# Build and run the decimating filter testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module dfTb -f tb.f -o simDf \
    && ./obj_dir/simDf > sim.log 2>&1 \
    || echo "build or simulation stopped with an error" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "RESULT: FAIL"; exit 1; }
grep -q "all tests passed" sim.log || { echo "RESULT: FAIL"; exit 1; }
echo "RESULT: PASS"
